/* rtl/core_pkg.sv */
// core_pkg: shared encodings for the pipelined core
// opcodes, function codes, alu operations, forwarding selects
// and the instruction word with its r-type and i-type views
`default_nettype none

package core_pkg;

    // major opcodes, mips numbering
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } op_t;

    // r-type function field
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_lui = 3'd5
    } alu_op_t;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_ex   = 2'd1,
        fwd_mem  = 2'd2
    } fwd_t;

    // one 32-bit instruction word, two decodings
    typedef union packed {
        struct packed {
            op_t        op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            funct_t     funct;
        } r;
        struct packed {
            op_t         op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } inst_t;

endpackage

`default_nettype wire

/* rtl/core_if.sv */
// core_if: program counter and instruction fetch
// fetches from a combinational instruction port into if_regs
`timescale 1ns/1ps
`default_nettype none

module core_if import core_pkg::*; #(
    parameter int DATA_W = 64
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall_fe,
    input  wire logic              stall_all,
    input  wire logic              flush,
    input  wire logic              branch_taken,
    input  wire logic [DATA_W-1:0] branch_target,
    input  wire logic [31:0]       i_data,
    output logic      [DATA_W-1:0] i_addr,
    output logic                   if_valid,
    output inst_t                  if_inst,
    output logic      [DATA_W-1:0] if_pc4
);
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pc4;
    logic [DATA_W-1:0] next_pc;

    assign i_addr = pc;
    assign pc4 = pc + DATA_W'(4);
    // branch resolved in execute overrides sequential fetch
    assign next_pc = branch_taken ? branch_target : pc4;

    // pc and if_regs valid bit
    always_ff @(posedge clock) begin
        if (reset) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (!stall_all) begin
            if (flush) begin
                // word fetched this cycle is on the wrong path
                pc       <= next_pc;
                if_valid <= 1'b0;
            end else if (!stall_fe) begin
                pc       <= next_pc;
                if_valid <= 1'b1;
            end
        end
    end

    // fetched word and its return address
    always_ff @(posedge clock) begin
        if (!stall_all && !stall_fe) begin
            if_inst <= inst_t'(i_data);
            if_pc4  <= pc4;
        end
    end

endmodule

`default_nettype wire

/* rtl/core_id.sv */
// core_id: decode and register read
// 32-entry register file with write-through, immediate extension
// and the id_regs stage register
`timescale 1ns/1ps
`default_nettype none

module core_id import core_pkg::*; #(
    parameter int DATA_W = 64
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall_fe,
    input  wire logic              stall_all,
    input  wire logic              flush,
    input  wire logic              if_valid,
    input  wire inst_t             if_inst,
    input  wire logic [DATA_W-1:0] if_pc4,
    input  wire logic              wb_en,
    input  wire logic [4:0]        wb_regnum,
    input  wire logic [DATA_W-1:0] wb_data,
    output logic                   id_valid,
    output alu_op_t                id_alu_op,
    output logic                   id_use_imm,
    output logic      [DATA_W-1:0] id_imm,
    output logic      [DATA_W-1:0] id_a,
    output logic      [DATA_W-1:0] id_b,
    output logic      [4:0]        id_rs,
    output logic      [4:0]        id_rt,
    output logic      [4:0]        id_dest,
    output logic                   id_we,
    output logic                   id_load,
    output logic                   id_store,
    output logic                   id_beq,
    output logic                   id_bne,
    output logic      [DATA_W-1:0] id_pc4
);
    logic [DATA_W-1:0] regs [32];
    logic [DATA_W-1:0] rf_a;
    logic [DATA_W-1:0] rf_b;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] imm_zext;
    alu_op_t           dec_alu_op;
    logic              dec_use_imm;
    logic              dec_zext;
    logic [4:0]        dec_dest;
    logic              dec_we;
    logic              dec_load;
    logic              dec_store;
    logic              dec_beq;
    logic              dec_bne;

    // register file, r0 never written
    always_ff @(posedge clock) begin
        if (wb_en && wb_regnum != 5'd0)
            regs[wb_regnum] <= wb_data;
    end

    // reads see the value being written back this cycle
    assign rf_a = (if_inst.r.rs == 5'd0) ? '0 :
                  (wb_en && wb_regnum == if_inst.r.rs) ? wb_data : regs[if_inst.r.rs];
    assign rf_b = (if_inst.r.rt == 5'd0) ? '0 :
                  (wb_en && wb_regnum == if_inst.r.rt) ? wb_data : regs[if_inst.r.rt];

    assign imm_sext = {{(DATA_W-16){if_inst.i.imm[15]}}, if_inst.i.imm};
    assign imm_zext = {{(DATA_W-16){1'b0}}, if_inst.i.imm};

    // decoder, unknown encodings become nops
    always_comb begin
        dec_alu_op  = alu_add;
        dec_use_imm = 1'b1;
        dec_zext    = 1'b0;
        dec_dest    = if_inst.i.rt;
        dec_we      = 1'b0;
        dec_load    = 1'b0;
        dec_store   = 1'b0;
        dec_beq     = 1'b0;
        dec_bne     = 1'b0;
        case (if_inst.r.op)
            op_rtype: begin
                dec_use_imm = 1'b0;
                dec_dest    = if_inst.r.rd;
                dec_we      = 1'b1;
                case (if_inst.r.funct)
                    fn_addu: dec_alu_op = alu_add;
                    fn_subu: dec_alu_op = alu_sub;
                    fn_and:  dec_alu_op = alu_and;
                    fn_or:   dec_alu_op = alu_or;
                    fn_slt:  dec_alu_op = alu_slt;
                    default: dec_we = 1'b0;
                endcase
            end
            op_addiu: dec_we = 1'b1;
            op_ori: begin
                dec_alu_op = alu_or;
                dec_zext   = 1'b1;
                dec_we     = 1'b1;
            end
            op_lui: begin
                dec_alu_op = alu_lui;
                dec_we     = 1'b1;
            end
            op_lw: begin
                dec_we   = 1'b1;
                dec_load = 1'b1;
            end
            op_sw: dec_store = 1'b1;
            // compare uses the register operands
            op_beq: dec_beq = 1'b1;
            op_bne: dec_bne = 1'b1;
            default: ;
        endcase
        // writes to r0 are dropped here so later stages never see them
        if (dec_dest == 5'd0)
            dec_we = 1'b0;
    end

    // id_regs valid bit, bubble on flush or load-use
    always_ff @(posedge clock) begin
        if (reset)
            id_valid <= 1'b0;
        else if (!stall_all)
            id_valid <= if_valid & ~flush & ~stall_fe;
    end

    // id_regs payload
    always_ff @(posedge clock) begin
        if (!stall_all) begin
            id_alu_op  <= dec_alu_op;
            id_use_imm <= dec_use_imm;
            id_imm     <= dec_zext ? imm_zext : imm_sext;
            id_a       <= rf_a;
            id_b       <= rf_b;
            id_rs      <= if_inst.r.rs;
            id_rt      <= if_inst.r.rt;
            id_dest    <= dec_dest;
            id_we      <= dec_we;
            id_load    <= dec_load;
            id_store   <= dec_store;
            id_beq     <= dec_beq;
            id_bne     <= dec_bne;
            id_pc4     <= if_pc4;
        end else begin
            // held during a bus wait, so catch the writeback that leaves mem_regs
            if (wb_en && wb_regnum == id_rs)
                id_a <= wb_data;
            if (wb_en && wb_regnum == id_rt)
                id_b <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/core_ex.sv */
// core_ex: execute stage
// operand forwarding, alu, branch resolution and the ex_regs register
`timescale 1ns/1ps
`default_nettype none

module core_ex import core_pkg::*; #(
    parameter int DATA_W = 64
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall_all,
    input  wire logic              id_valid,
    input  wire alu_op_t           id_alu_op,
    input  wire logic              id_use_imm,
    input  wire logic [DATA_W-1:0] id_imm,
    input  wire logic [DATA_W-1:0] id_a,
    input  wire logic [DATA_W-1:0] id_b,
    input  wire logic [4:0]        id_dest,
    input  wire logic              id_we,
    input  wire logic              id_load,
    input  wire logic              id_store,
    input  wire logic              id_beq,
    input  wire logic              id_bne,
    input  wire logic [DATA_W-1:0] id_pc4,
    input  wire fwd_t              fwd_a,
    input  wire fwd_t              fwd_b,
    input  wire logic [DATA_W-1:0] wb_data,
    output logic                   branch_taken,
    output logic      [DATA_W-1:0] branch_target,
    output logic                   ex_valid,
    output logic      [DATA_W-1:0] ex_out,
    output logic      [DATA_W-1:0] ex_b,
    output logic      [4:0]        ex_dest,
    output logic                   ex_we,
    output logic                   ex_load,
    output logic                   ex_store
);
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b_reg;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_out;
    logic              equal;

    // forwarding muxes
    always_comb begin
        case (fwd_a)
            fwd_ex:  op_a = ex_out;
            fwd_mem: op_a = wb_data;
            default: op_a = id_a;
        endcase
        case (fwd_b)
            fwd_ex:  op_b_reg = ex_out;
            fwd_mem: op_b_reg = wb_data;
            default: op_b_reg = id_b;
        endcase
    end

    assign op_b = id_use_imm ? id_imm : op_b_reg;

    // alu, also forms load and store addresses
    always_comb begin
        case (id_alu_op)
            alu_sub: alu_out = op_a - op_b;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_slt: alu_out = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_lui: alu_out = {op_b[DATA_W-17:0], 16'h0000};
            default: alu_out = op_a + op_b;
        endcase
    end

    // branches compare the two register operands
    assign equal = (op_a == op_b_reg);
    assign branch_taken = id_valid & ((id_beq & equal) | (id_bne & ~equal));
    // word offset from the instruction after the branch
    assign branch_target = id_pc4 + {id_imm[DATA_W-3:0], 2'b00};

    // ex_regs control, bus request flags qualified by valid
    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
        end else if (!stall_all) begin
            ex_valid <= id_valid;
            // branches never carry a write
            ex_we    <= id_valid & id_we;
            ex_load  <= id_valid & id_load;
            ex_store <= id_valid & id_store;
        end
    end

    // ex_regs payload
    always_ff @(posedge clock) begin
        if (!stall_all) begin
            ex_out  <= alu_out;
            ex_b    <= op_b_reg;
            ex_dest <= id_dest;
        end
    end

endmodule

`default_nettype wire

/* rtl/core_mem.sv */
// core_mem: memory and writeback register
// picks load data or alu result into mem_regs
`timescale 1ns/1ps
`default_nettype none

module core_mem #(
    parameter int DATA_W = 64
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              stall_all,
    input  wire logic              ex_valid,
    input  wire logic [DATA_W-1:0] ex_out,
    input  wire logic [4:0]        ex_dest,
    input  wire logic              ex_we,
    input  wire logic              ex_load,
    input  wire logic [DATA_W-1:0] d_rdata,
    output logic                   wb_en,
    output logic      [4:0]        wb_regnum,
    output logic      [DATA_W-1:0] wb_data
);
    // mem_regs write enable doubles as its valid bit
    always_ff @(posedge clock) begin
        if (reset)
            wb_en <= 1'b0;
        else if (stall_all)
            // access still pending, pass a bubble
            wb_en <= 1'b0;
        else
            wb_en <= ex_valid & ex_we;
    end

    // load data is valid in the cycle d_ready is seen
    always_ff @(posedge clock) begin
        if (!stall_all) begin
            wb_regnum <= ex_dest;
            wb_data   <= ex_load ? d_rdata : ex_out;
        end
    end

endmodule

`default_nettype wire

/* rtl/core_hazard.sv */
// core_hazard: pipeline control
// forwarding selects, load-use and bus-wait stalls, branch flush
`timescale 1ns/1ps
`default_nettype none

module core_hazard import core_pkg::*; (
    input  wire logic       if_valid,
    input  wire inst_t      if_inst,
    input  wire logic       id_valid,
    input  wire logic [4:0] id_rs,
    input  wire logic [4:0] id_rt,
    input  wire logic [4:0] id_dest,
    input  wire logic       id_we,
    input  wire logic       id_load,
    input  wire logic       ex_valid,
    input  wire logic [4:0] ex_dest,
    input  wire logic       ex_we,
    input  wire logic       ex_load,
    input  wire logic       wb_en,
    input  wire logic [4:0] wb_regnum,
    input  wire logic       branch_taken,
    input  wire logic       d_valid,
    input  wire logic       d_ready,
    output logic            stall_fe,
    output logic            stall_all,
    output logic            flush,
    output fwd_t            fwd_a,
    output fwd_t            fwd_b
);
    logic ex_fwd_ok;

    // loads in ex_regs have no data yet
    assign ex_fwd_ok = ex_valid & ex_we & ~ex_load;

    // younger result wins
    assign fwd_a = (ex_fwd_ok && ex_dest == id_rs) ? fwd_ex :
                   (wb_en && wb_regnum == id_rs) ? fwd_mem : fwd_none;
    assign fwd_b = (ex_fwd_ok && ex_dest == id_rt) ? fwd_ex :
                   (wb_en && wb_regnum == id_rt) ? fwd_mem : fwd_none;

    // load in id_regs feeding the next instruction
    assign stall_fe = id_valid & id_load & id_we & if_valid &
                      (id_dest == if_inst.r.rs || id_dest == if_inst.r.rt);

    // data bus not answered yet
    assign stall_all = d_valid & ~d_ready;

    // redirect only when the branch actually leaves id_regs
    assign flush = branch_taken & ~stall_all;

endmodule

`default_nettype wire

/* rtl/core.sv */
// core: four-stage pipelined mips-like integer core
// combinational instruction port, valid/ready data bus
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; #(
    parameter int DATA_W = 64
) (
    input  wire logic              clock,
    input  wire logic              reset,
    output logic      [DATA_W-1:0] i_addr,
    input  wire logic [31:0]       i_data,
    output logic      [DATA_W-1:0] d_addr,
    output logic      [DATA_W-1:0] d_wdata,
    input  wire logic [DATA_W-1:0] d_rdata,
    output logic                   d_word_we,
    output logic                   d_valid,
    input  wire logic              d_ready
);
    // pipeline control
    logic              stall_fe;
    logic              stall_all;
    logic              flush;
    fwd_t              fwd_a;
    fwd_t              fwd_b;
    logic              branch_taken;
    logic [DATA_W-1:0] branch_target;

    // if_regs
    logic              if_valid;
    inst_t             if_inst;
    logic [DATA_W-1:0] if_pc4;

    // id_regs
    logic              id_valid;
    alu_op_t           id_alu_op;
    logic              id_use_imm;
    logic [DATA_W-1:0] id_imm;
    logic [DATA_W-1:0] id_a;
    logic [DATA_W-1:0] id_b;
    logic [4:0]        id_rs;
    logic [4:0]        id_rt;
    logic [4:0]        id_dest;
    logic              id_we;
    logic              id_load;
    logic              id_store;
    logic              id_beq;
    logic              id_bne;
    logic [DATA_W-1:0] id_pc4;

    // ex_regs
    logic              ex_valid;
    logic [DATA_W-1:0] ex_out;
    logic [DATA_W-1:0] ex_b;
    logic [4:0]        ex_dest;
    logic              ex_we;
    logic              ex_load;
    logic              ex_store;

    // mem_regs
    logic              wb_en;
    logic [4:0]        wb_regnum;
    logic [DATA_W-1:0] wb_data;

    // stage ports share names with the nets above
    core_if #(.DATA_W(DATA_W)) if_stage (.*);
    core_id #(.DATA_W(DATA_W)) id_stage (.*);
    core_ex #(.DATA_W(DATA_W)) ex_stage (.*);
    core_mem #(.DATA_W(DATA_W)) mem_stage (.*);
    core_hazard hazard_unit (.*);

    // data bus straight from ex_regs, held by stall_all until d_ready
    assign d_valid   = ex_load | ex_store;
    assign d_word_we = ex_store;
    assign d_addr    = ex_out;
    assign d_wdata   = ex_b;

endmodule

`default_nettype wire

/* bench/core_properties.sv */
// core_properties checks the core data bus and pipeline freeze
// covers reset state, request stability and fetch hold while waiting
`timescale 1ns/1ps
`default_nettype none

module core_properties #(
    parameter int DATA_W = 64
) (
    input wire logic              clock,
    input wire logic              reset,
    input wire logic [DATA_W-1:0] i_addr,
    input wire logic              d_valid,
    input wire logic              d_ready,
    input wire logic              d_word_we,
    input wire logic [DATA_W-1:0] d_addr,
    input wire logic [DATA_W-1:0] d_wdata
);
    // bus idle once a reset edge has been taken
    reset_idle: assert property (@(posedge clock) reset |=> (!d_valid && !d_word_we))
        else $error("data bus request active right after reset");

    // request held unchanged until d_ready
    request_stable: assert property (@(posedge clock) disable iff (reset)
        (d_valid && !d_ready) |=> (d_valid && $stable(d_addr) && $stable(d_wdata)
                                   && $stable(d_word_we)))
        else $error("data bus request changed while waiting for d_ready");

    // pc held along with every stage while the bus waits
    fetch_frozen: assert property (@(posedge clock) disable iff (reset)
        (d_valid && !d_ready) |=> $stable(i_addr))
        else $error("fetch address moved while the data bus was waiting");

endmodule

bind core core_properties #(.DATA_W(DATA_W)) i_properties (
    .clock(clock),
    .reset(reset),
    .i_addr(i_addr),
    .d_valid(d_valid),
    .d_ready(d_ready),
    .d_word_we(d_word_we),
    .d_addr(d_addr),
    .d_wdata(d_wdata)
);

`default_nettype wire

/* bench/core_tb.sv */
// core_tb runs an lfsr-built random program on the pipelined core
// with random bus delays and an in-order instruction-set model
// store stream and final memory compared against the model
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();
    localparam int DATA_W     = 64;
    localparam int CLK_PERIOD = 4;
    localparam int N_BODY     = 60;
    // prologue then random body, register dump and self-branch
    localparam int PROG_LEN   = 14 + N_BODY + 7 + 1;
    localparam int MEM_SLOTS  = 16;

    logic              clock;
    logic              reset;
    logic [DATA_W-1:0] i_addr;
    logic [31:0]       i_data;
    logic [DATA_W-1:0] d_addr;
    logic [DATA_W-1:0] d_wdata;
    logic [DATA_W-1:0] d_rdata;
    logic              d_word_we;
    logic              d_valid;
    logic              d_ready;

    logic [31:0]       lfsr;
    logic [31:0]       prog [PROG_LEN];
    logic [63:0]       tb_mem [MEM_SLOTS];
    logic [63:0]       model_mem [MEM_SLOTS];
    logic [63:0]       exp_addr [$];
    logic [63:0]       exp_data [$];
    int                n_stores;
    int                mismatches;
    int                failures;
    int                wait_cnt;
    int                delay;

    core #(.DATA_W(DATA_W)) i_core (
        .clock(clock),
        .reset(reset),
        .i_addr(i_addr),
        .i_data(i_data),
        .d_addr(d_addr),
        .d_wdata(d_wdata),
        .d_rdata(d_rdata),
        .d_word_we(d_word_we),
        .d_valid(d_valid),
        .d_ready(d_ready)
    );

    // instruction rom returns nop outside the program
    assign i_data = (i_addr < DATA_W'(PROG_LEN * 4)) ? prog[i_addr[8:2]] : 32'h0;

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] v;
        v = rand_bits(3);
        return 5'(v % 7 + 1);
    endfunction

    // initial memory word built from every address bit
    function automatic logic [63:0] fill_word(input int slot);
        return {32'(slot) * 32'h9e3779b9, ~(32'(slot) * 32'd8)};
    endfunction

    function automatic logic [31:0] encode_r(input funct_t fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd);
        return {op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_i(input op_t op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] offset;
        logic [15:0] slot_addr;
        logic [3:0]  sel;
        logic [31:0] w;
        rs        = pick_reg();
        rt        = pick_reg();
        rd        = pick_reg();
        imm       = 16'(rand_bits(16));
        offset    = 16'(rand_bits(2) % 3 + 1);
        sel       = 4'(rand_bits(4));
        // doubleword slot off r0
        slot_addr = {9'd0, imm[3:0], 3'd0};
        case (sel)
            4'd0, 4'd1:   w = encode_r(fn_addu, rs, rt, rd);
            4'd2:         w = encode_r(fn_subu, rs, rt, rd);
            4'd3:         w = encode_r(fn_and, rs, rt, rd);
            4'd4:         w = encode_r(fn_or, rs, rt, rd);
            4'd5:         w = encode_r(fn_slt, rs, rt, rd);
            4'd6, 4'd7:   w = encode_i(op_addiu, rs, rt, imm);
            4'd8:         w = encode_i(op_ori, rs, rt, imm);
            4'd9:         w = encode_i(op_lui, 5'd0, rt, imm);
            4'd10, 4'd11: w = encode_i(op_lw, 5'd0, rt, slot_addr);
            4'd12, 4'd13: w = encode_i(op_sw, 5'd0, rt, slot_addr);
            // forward branches skip 1 to 3 instructions
            4'd14:        w = encode_i(op_beq, rs, rt, offset);
            default:      w = encode_i(op_bne, rs, rt, offset);
        endcase
        return w;
    endfunction

    task automatic build_program();
        int idx;
        idx = 0;
        // known start values in r1..r7
        for (int r = 1; r < 8; r++) begin
            prog[7'(idx)]     = encode_i(op_lui, 5'd0, 5'(r), 16'(rand_bits(16)));
            prog[7'(idx + 1)] = encode_i(op_ori, 5'(r), 5'(r), 16'(rand_bits(16)));
            idx = idx + 2;
        end
        for (int k = 0; k < N_BODY; k++) begin
            prog[7'(idx)] = random_inst();
            idx = idx + 1;
        end
        // register dump into slots 9..15
        for (int r = 1; r < 8; r++) begin
            prog[7'(idx)] = encode_i(op_sw, 5'd0, 5'(r), 16'((r + 8) * 8));
            idx = idx + 1;
        end
        prog[7'(idx)] = encode_i(op_beq, 5'd0, 5'd0, 16'hffff);
    endtask

    // in-order instruction-set model
    task automatic run_model();
        logic [63:0] regs [32];
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_s;
        logic [63:0] imm_z;
        logic [63:0] addr;
        logic [31:0] w;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          pc;
        for (int r = 0; r < 32; r++)
            regs[5'(r)] = '0;
        pc = 0;
        while (pc < PROG_LEN - 1) begin
            w     = prog[7'(pc)];
            rs    = w[25:21];
            rt    = w[20:16];
            rd    = w[15:11];
            a     = regs[rs];
            b     = regs[rt];
            imm_s = {{48{w[15]}}, w[15:0]};
            imm_z = {48'd0, w[15:0]};
            addr  = a + imm_s;
            pc    = pc + 1;
            case (w[31:26])
                op_rtype: begin
                    case (w[5:0])
                        fn_addu: regs[rd] = a + b;
                        fn_subu: regs[rd] = a - b;
                        fn_and:  regs[rd] = a & b;
                        fn_or:   regs[rd] = a | b;
                        fn_slt:  regs[rd] = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        default: ;
                    endcase
                end
                op_addiu: regs[rt] = a + imm_s;
                op_ori:   regs[rt] = a | imm_z;
                // 64-bit lui sign-extends the upper half
                op_lui:   regs[rt] = {{32{w[15]}}, w[15:0], 16'h0000};
                op_lw:    regs[rt] = model_mem[addr[6:3]];
                op_sw: begin
                    model_mem[addr[6:3]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                op_beq: if (a == b) pc = pc + int'($signed(w[15:0]));
                op_bne: if (a != b) pc = pc + int'($signed(w[15:0]));
                default: ;
            endcase
            regs[0] = '0;
        end
    endtask

    // one bus transfer that completes at the coming rising edge
    task automatic serve_access();
        logic [3:0] slot;
        slot = d_addr[6:3];
        assert (d_addr < 64'd128 && d_addr[2:0] == 3'd0) else begin
            failures++;
            $display("bus address %h at %0t is outside the data memory", d_addr, $time);
        end
        if (d_word_we === 1'b1) begin
            tb_mem[slot] = d_wdata;
            assert (n_stores < exp_addr.size()) else begin
                failures++;
                $display("unexpected extra store at %0t to address %h", $time, d_addr);
            end
            if (n_stores < exp_addr.size()) begin
                assert (d_addr == exp_addr[n_stores] && d_wdata == exp_data[n_stores])
                else begin
                    mismatches++;
                    $display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, n_stores, d_wdata, d_addr,
                             exp_data[n_stores], exp_addr[n_stores]);
                end
            end
            n_stores++;
        end else begin
            d_rdata <= tb_mem[slot];
        end
    endtask

    // bus responder with random wait states
    always @(negedge clock) begin
        if (reset) begin
            d_ready  <= 1'b0;
            wait_cnt = 0;
        end else if (d_valid === 1'b1) begin
            if (wait_cnt >= delay) begin
                serve_access();
                d_ready  <= 1'b1;
                wait_cnt = 0;
                delay    = int'(rand_bits(2));
            end else begin
                d_ready  <= 1'b0;
                wait_cnt = wait_cnt + 1;
            end
        end else begin
            d_ready <= 1'b0;
        end
    end

    initial begin
        reset      = 1'b1;
        d_ready    <= 1'b0;
        d_rdata    <= '0;
        lfsr       = 32'hd8b72571;
        n_stores   = 0;
        mismatches = 0;
        failures   = 0;
        wait_cnt   = 0;
        build_program();
        for (int s = 0; s < MEM_SLOTS; s++) begin
            tb_mem[4'(s)]    = fill_word(s);
            model_mem[4'(s)] = fill_word(s);
        end
        run_model();
        delay = int'(rand_bits(2));
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        while (n_stores < exp_addr.size())
            @(posedge clock);
        // a few more cycles so a stray late store shows up
        repeat (8) @(posedge clock);
        assert (n_stores == exp_addr.size()) else begin
            failures++;
            $display("store count %0d differs from expected %0d", n_stores, exp_addr.size());
        end
        for (int s = 0; s < MEM_SLOTS; s++) begin
            assert (tb_mem[4'(s)] == model_mem[4'(s)]) else begin
                mismatches++;
                $display("MISMATCH at %0t: memory slot %0d holds %h, expected %h",
                         $time, s, tb_mem[4'(s)], model_mem[4'(s)]);
            end
        end
        $display("error count: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog allows 12 cycles per instruction plus reset
    initial begin
        #(PROG_LEN * 12 * CLK_PERIOD + 3 * CLK_PERIOD);
        $display("timeout: only %0d of %0d stores seen before the time limit",
                 n_stores, exp_addr.size());
        $display("error count: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/core_pkg.sv
rtl/core_if.sv
rtl/core_id.sv
rtl/core_ex.sv
rtl/core_mem.sv
rtl/core_hazard.sv
rtl/core.sv
bench/core_properties.sv
bench/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
